//--- Makefile
# Verilator build and run for the PWM unit testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_pwm_top
FILELIST = pwm_unit.f
OBJ_DIR  = obj_dir

BIN   = $(OBJ_DIR)/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FILELIST))
CASES = sim/pwm_cases.txt

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- pwm_unit.f
rtl/pwm_pkg.sv
rtl/pwm_glbl_reg.sv
rtl/pwm_core.sv
rtl/pwm_top.sv
sim/tb_clk_gen.sv
sim/tb_pwm_top.sv

//--- rtl/pwm_core.sv
//----------------------------------------------------------------------------
// One PWM channel with its register window
// Shadow period and compare, prescaler, counter, compare and GPIO trigger
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module pwm_core (
    input  logic                mclk,
    input  logic                rst_n,

    input  logic                reg_cs,
    input  logic                reg_wr,
    input  pwm_pkg::reg_addr_t  reg_addr,
    input  pwm_pkg::reg_data_t  reg_wdata,
    input  pwm_pkg::reg_be_t    reg_be,
    output pwm_pkg::reg_data_t  reg_rdata,
    output logic                reg_ack,

    input  logic                cfg_enb,    // From global enable
    input  logic                cfg_hold,   // Blocks shadow to active copy
    input  pwm_pkg::gpio_t      pad_gpio,

    output logic                os_done,    // Single cycle strobes
    output logic                ovflow,
    output logic                gpio_tgr,
    output logic                pwm_wfm
);
    import pwm_pkg::*;

    // Config fields
    logic       cfg_oneshot;
    logic       cfg_trig;
    logic       cfg_pol;
    gpio_sel_t  cfg_gsel;
    pwm_presc_t cfg_presc;

    pwm_cnt_t   per_sh;                 // Shadow values written by software
    pwm_cnt_t   cmp_sh;
    pwm_cnt_t   per_act;                // Values the counter runs on
    pwm_cnt_t   cmp_act;
    pwm_cnt_t   cnt;
    pwm_presc_t psc;
    pwm_state_e state;

    reg_data_t  rd_mux;
    reg_data_t  wr_val;
    logic       wr_en;
    logic       gpio_bit;
    logic       gpio_q;
    logic       gpio_rise;
    logic       tick;
    logic       wrap;

    //------------------------------------------------------------------------
    // Register access
    //------------------------------------------------------------------------
    assign wr_en  = reg_cs & reg_wr & ~reg_ack;
    assign wr_val = be_merge(rd_mux, reg_wdata, reg_be);

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            CH_CFG: begin
                rd_mux[CFG_ONESHOT_BIT]                         = cfg_oneshot;
                rd_mux[CFG_TRIG_BIT]                            = cfg_trig;
                rd_mux[CFG_POL_BIT]                             = cfg_pol;
                rd_mux[CFG_GSEL_LSB +: $bits(gpio_sel_t)]       = cfg_gsel;
                rd_mux[CFG_PRESC_LSB +: $bits(pwm_presc_t)]     = cfg_presc;
            end
            CH_PERIOD:  rd_mux = reg_data_t'(per_sh);
            CH_COMPARE: rd_mux = reg_data_t'(cmp_sh);
            CH_COUNT:   rd_mux = reg_data_t'(cnt);      // Live count
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            reg_ack   <= 1'b0;
            reg_rdata <= '0;
        end else begin
            reg_ack <= reg_cs & ~reg_ack;
            if (reg_cs & ~reg_ack) reg_rdata <= rd_mux;
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            cfg_oneshot <= 1'b0;
            cfg_trig    <= 1'b0;
            cfg_pol     <= 1'b0;
            cfg_gsel    <= '0;
            cfg_presc   <= '0;
            per_sh      <= '0;
            cmp_sh      <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                CH_CFG: begin
                    cfg_oneshot <= wr_val[CFG_ONESHOT_BIT];
                    cfg_trig    <= wr_val[CFG_TRIG_BIT];
                    cfg_pol     <= wr_val[CFG_POL_BIT];
                    cfg_gsel    <= wr_val[CFG_GSEL_LSB +: $bits(gpio_sel_t)];
                    cfg_presc   <= wr_val[CFG_PRESC_LSB +: $bits(pwm_presc_t)];
                end
                CH_PERIOD:  per_sh <= wr_val[$bits(pwm_cnt_t)-1:0];
                CH_COMPARE: cmp_sh <= wr_val[$bits(pwm_cnt_t)-1:0];
                default: ;  // Count is read only
            endcase
        end
    end

    //------------------------------------------------------------------------
    // Channel FSM, prescaler and counter
    //------------------------------------------------------------------------
    assign gpio_bit  = pad_gpio[cfg_gsel];
    assign gpio_rise = gpio_bit & ~gpio_q;
    assign tick      = (psc == cfg_presc);
    assign wrap      = tick && (cnt == per_act - 1'b1);    // Last step of period

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            psc      <= '0;
            cnt      <= '0;
            per_act  <= '0;
            cmp_act  <= '0;
            gpio_q   <= 1'b0;
            os_done  <= 1'b0;
            ovflow   <= 1'b0;
            gpio_tgr <= 1'b0;
            pwm_wfm  <= 1'b0;
        end else begin
            gpio_q   <= gpio_bit;
            os_done  <= 1'b0;
            ovflow   <= 1'b0;
            gpio_tgr <= 1'b0;
            if (!cfg_enb) begin
                state   <= ST_IDLE;
                psc     <= '0;
                cnt     <= '0;
                per_act <= per_sh;      // Start from fresh config
                cmp_act <= cmp_sh;
            end else begin
                case (state)
                    ST_IDLE: begin
                        per_act <= per_sh;
                        cmp_act <= cmp_sh;
                        state   <= cfg_trig ? ST_WAIT_TRIG : ST_RUN;
                    end
                    ST_WAIT_TRIG: begin
                        per_act <= per_sh;
                        cmp_act <= cmp_sh;
                        if (gpio_rise) begin
                            state    <= ST_RUN;
                            gpio_tgr <= 1'b1;
                        end
                    end
                    ST_RUN: begin
                        if (!tick) begin
                            psc <= psc + 1'b1;
                        end else begin
                            psc <= '0;
                            if (!wrap) begin
                                cnt <= cnt + 1'b1;
                            end else begin
                                cnt <= '0;
                                if (!cfg_hold) begin
                                    per_act <= per_sh;
                                    cmp_act <= cmp_sh;
                                end
                                if (cfg_oneshot) begin
                                    os_done <= 1'b1;
                                    state   <= ST_DONE;
                                end else begin
                                    ovflow  <= 1'b1;
                                end
                            end
                        end
                    end
                    default: ;  // ST_DONE parks until disabled
                endcase
            end
            // One stage behind the counter, inactive level outside RUN
            pwm_wfm <= (state == ST_RUN) ? ((cnt < cmp_act) ^ cfg_pol) : cfg_pol;
        end
    end

    // Active period only changes at wrap or when stopped
    a_cnt_range: assert property (@(posedge mclk) disable iff (!rst_n)
        (per_act != '0) |-> (cnt < per_act));

    a_evt_excl: assert property (@(posedge mclk) disable iff (!rst_n)
        !(os_done && ovflow));

endmodule

//--- rtl/pwm_glbl_reg.sv
//----------------------------------------------------------------------------
// Global register window of the PWM unit
// Channel enables, hold bits, W1C event status, mask and the interrupt line
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module pwm_glbl_reg #(
    parameter int NUM_CH = 6
) (
    input  logic                mclk,
    input  logic                rst_n,

    input  logic                reg_cs,     // Already gated by window decode
    input  logic                reg_wr,
    input  pwm_pkg::reg_addr_t  reg_addr,
    input  pwm_pkg::reg_data_t  reg_wdata,
    input  pwm_pkg::reg_be_t    reg_be,
    output pwm_pkg::reg_data_t  reg_rdata,
    output logic                reg_ack,

    input  logic [NUM_CH-1:0]   os_done,    // Event strobes from channels
    input  logic [NUM_CH-1:0]   ovflow,
    input  logic [NUM_CH-1:0]   gpio_tgr,

    output logic [NUM_CH-1:0]   cfg_enb,
    output logic [NUM_CH-1:0]   cfg_hold,
    output logic                pwm_intr
);
    import pwm_pkg::*;

    logic [NUM_CH-1:0] sts_evt;         // Overflow or one-shot done
    logic [NUM_CH-1:0] sts_tgr;         // GPIO trigger seen
    logic [NUM_CH-1:0] msk_evt;
    logic [NUM_CH-1:0] msk_tgr;
    logic [NUM_CH-1:0] clr_evt;
    logic [NUM_CH-1:0] clr_tgr;
    reg_data_t         rd_mux;
    reg_data_t         wr_val;
    reg_data_t         clr_val;
    logic              wr_en;
    logic              sts_wr;

    //------------------------------------------------------------------------
    // Register access
    //------------------------------------------------------------------------
    assign wr_en   = reg_cs & reg_wr & ~reg_ack;    // Once per access
    assign wr_val  = be_merge(rd_mux, reg_wdata, reg_be);
    assign clr_val = be_merge('0, reg_wdata, reg_be);   // Ones only in enabled lanes
    assign sts_wr  = wr_en && (reg_addr == GL_STATUS);
    assign clr_evt = sts_wr ? clr_val[NUM_CH-1:0] : '0;
    assign clr_tgr = sts_wr ? clr_val[STS_TGR_LSB +: NUM_CH] : '0;

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            GL_ENABLE: rd_mux = reg_data_t'(cfg_enb);
            GL_HOLD:   rd_mux = reg_data_t'(cfg_hold);
            GL_STATUS: begin
                rd_mux[NUM_CH-1:0]            = sts_evt;
                rd_mux[STS_TGR_LSB +: NUM_CH] = sts_tgr;
            end
            GL_MASK: begin
                rd_mux[NUM_CH-1:0]            = msk_evt;
                rd_mux[STS_TGR_LSB +: NUM_CH] = msk_tgr;
            end
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            reg_ack   <= 1'b0;
            reg_rdata <= '0;
        end else begin
            reg_ack <= reg_cs & ~reg_ack;               // One cycle pulse
            if (reg_cs & ~reg_ack) reg_rdata <= rd_mux;
        end
    end

    // Enable, hold and mask
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            cfg_enb  <= '0;
            cfg_hold <= '0;
            msk_evt  <= '0;
            msk_tgr  <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                GL_ENABLE: cfg_enb  <= wr_val[NUM_CH-1:0];
                GL_HOLD:   cfg_hold <= wr_val[NUM_CH-1:0];
                GL_MASK: begin
                    msk_evt <= wr_val[NUM_CH-1:0];
                    msk_tgr <= wr_val[STS_TGR_LSB +: NUM_CH];
                end
                default: ;  // Status handled below
            endcase
        end
    end

    //------------------------------------------------------------------------
    // Status and interrupt
    //------------------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            sts_evt  <= '0;
            sts_tgr  <= '0;
            pwm_intr <= 1'b0;
        end else begin
            sts_evt  <= (sts_evt & ~clr_evt) | ovflow | os_done;   // Set beats clear
            sts_tgr  <= (sts_tgr & ~clr_tgr) | gpio_tgr;
            pwm_intr <= |{sts_evt & msk_evt, sts_tgr & msk_tgr};   // Lags status by one
        end
    end

    // Ack must drop after one cycle even while cs is still held
    a_ack_single: assert property (@(posedge mclk) disable iff (!rst_n)
        reg_ack |=> !reg_ack);

endmodule

//--- rtl/pwm_pkg.sv
//----------------------------------------------------------------------------
// Shared types, register offsets and CH_CFG field positions for the PWM unit
// Every RTL module pulls this in with a wildcard import
//----------------------------------------------------------------------------
package pwm_pkg;

    typedef logic [1:0]  reg_addr_t;    // Offset inside one register window
    typedef logic [31:0] reg_data_t;    // Bus data
    typedef logic [3:0]  reg_be_t;      // Byte enables
    typedef logic [15:0] pwm_cnt_t;     // Period, compare, counter
    typedef logic [3:0]  pwm_presc_t;   // Prescale divider minus one
    typedef logic [2:0]  gpio_sel_t;    // Trigger pad index
    typedef logic [7:0]  gpio_t;        // Pad GPIO vector

    // Channel window offsets
    localparam reg_addr_t CH_CFG     = 2'd0;
    localparam reg_addr_t CH_PERIOD  = 2'd1;
    localparam reg_addr_t CH_COMPARE = 2'd2;
    localparam reg_addr_t CH_COUNT   = 2'd3;   // Read only

    // Global window offsets
    localparam reg_addr_t GL_ENABLE  = 2'd0;
    localparam reg_addr_t GL_HOLD    = 2'd1;
    localparam reg_addr_t GL_STATUS  = 2'd2;   // Write 1 to clear
    localparam reg_addr_t GL_MASK    = 2'd3;

    // CH_CFG mode bits
    localparam int CFG_ONESHOT_BIT = 0;
    localparam int CFG_TRIG_BIT    = 1;
    localparam int CFG_POL_BIT     = 2;
    localparam int CFG_GSEL_LSB    = 4;
    localparam int CFG_PRESC_LSB   = 8;

    localparam int STS_TGR_LSB     = 8;    // GPIO trigger field in status and mask

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_TRIG,
        ST_RUN,
        ST_DONE
    } pwm_state_e;

    // Byte lane merge for partial writes
    function automatic reg_data_t be_merge(input reg_data_t cur, input reg_data_t wdata,
                                           input reg_be_t be);
        reg_data_t res;
        res = cur;
        for (int i = 0; i < $bits(reg_be_t); i++) begin
            if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

endpackage

//--- rtl/pwm_top.sv
//----------------------------------------------------------------------------
// PWM unit top level
// Splits the register bus into a global window and one window per channel
// and builds NUM_CH channels around the global register block
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module pwm_top #(
    parameter int NUM_CH = 6                    // 1 to 7 channels
) (
    input  logic                mclk,
    input  logic                rst_n,

    input  logic                reg_cs,
    input  logic                reg_wr,
    input  logic [4:0]          reg_addr,       // Window in [4:2], offset in [1:0]
    input  pwm_pkg::reg_data_t  reg_wdata,
    input  pwm_pkg::reg_be_t    reg_be,
    output pwm_pkg::reg_data_t  reg_rdata,
    output logic                reg_ack,

    input  pwm_pkg::gpio_t      pad_gpio,
    output logic [NUM_CH-1:0]   pwm_wfm,
    output logic                pwm_intr
);
    import pwm_pkg::*;

    logic [2:0]        win;
    reg_addr_t         ofs;
    logic [NUM_CH:0]   cs_win;              // Index 0 is the global window
    logic [NUM_CH:0]   ack_win;
    reg_data_t         rdata_win [NUM_CH+1];

    logic [NUM_CH-1:0] cfg_enb;
    logic [NUM_CH-1:0] cfg_hold;
    logic [NUM_CH-1:0] os_done;
    logic [NUM_CH-1:0] ovflow;
    logic [NUM_CH-1:0] gpio_tgr;

    //------------------------------------------------------------------------
    // Window decode and return mux
    //------------------------------------------------------------------------
    assign win = reg_addr[4:2];
    assign ofs = reg_addr[1:0];

    always_comb begin
        for (int i = 0; i <= NUM_CH; i++) begin
            cs_win[i] = reg_cs && (win == i);
        end
    end

    // Unmapped windows return zero and never ack
    always_comb begin
        reg_rdata = '0;
        reg_ack   = 1'b0;
        for (int i = 0; i <= NUM_CH; i++) begin
            if (win == i) begin
                reg_rdata = rdata_win[i];
                reg_ack   = ack_win[i];
            end
        end
    end

    pwm_glbl_reg #(
        .NUM_CH    (NUM_CH)
    ) u_glbl_reg (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .reg_cs    (cs_win[0]),
        .reg_wr    (reg_wr),
        .reg_addr  (ofs),
        .reg_wdata (reg_wdata),
        .reg_be    (reg_be),
        .reg_rdata (rdata_win[0]),
        .reg_ack   (ack_win[0]),
        .os_done   (os_done),
        .ovflow    (ovflow),
        .gpio_tgr  (gpio_tgr),
        .cfg_enb   (cfg_enb),
        .cfg_hold  (cfg_hold),
        .pwm_intr  (pwm_intr)
    );

    // Channel n lives in window n+1
    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        pwm_core u_pwm (
            .mclk      (mclk),
            .rst_n     (rst_n),
            .reg_cs    (cs_win[g+1]),
            .reg_wr    (reg_wr),
            .reg_addr  (ofs),
            .reg_wdata (reg_wdata),
            .reg_be    (reg_be),
            .reg_rdata (rdata_win[g+1]),
            .reg_ack   (ack_win[g+1]),
            .cfg_enb   (cfg_enb[g]),
            .cfg_hold  (cfg_hold[g]),
            .pad_gpio  (pad_gpio),
            .os_done   (os_done[g]),
            .ovflow    (ovflow[g]),
            .gpio_tgr  (gpio_tgr[g]),
            .pwm_wfm   (pwm_wfm[g])
        );
    end

    // Decode must never let two windows answer together
    a_ack_onehot: assert property (@(posedge mclk) disable iff (!rst_n)
        $onehot0(ack_win));

endmodule

//--- sim/pwm_cases.txt
# op win ofs data be exp, hex; W write, R read (data is compare mask), I intr level in exp
# D rising edge then count ofs level over data cycles, S steady ofs level, G pad bit pulse
R 0 0 ffffffff 0 00000000
R 2 1 ffffffff 0 00000000
W 1 0 00000a17 f 0
W 1 0 ffffffff 1 0
R 1 0 ffffffff 0 00000a77
W 6 2 12345678 3 0
R 6 2 ffffffff 0 00005678
W 0 3 ffffffff f 0
R 0 3 ffffffff 0 00003f3f
W 0 3 00000000 f 0
W 1 0 00000100 f 0
W 1 1 00000008 f 0
W 1 2 00000003 f 0
W 0 0 00000001 f 0
D 1 1 00000010 0 00000006
W 0 1 00000001 f 0
W 1 2 00000005 f 0
D 1 1 00000010 0 00000006
W 0 1 00000000 f 0
D 1 1 00000010 0 0000000a
W 2 0 00000004 f 0
W 2 1 00000005 f 0
W 2 2 00000002 f 0
W 0 0 00000003 f 0
D 2 0 00000005 0 00000002
W 3 0 00000101 f 0
W 3 1 00000008 f 0
W 3 2 00000003 f 0
I 0 0 00000000 0 00000000
W 0 0 00000007 f 0
D 3 1 00000040 0 00000006
R 0 2 00000004 0 00000004
W 0 3 00000004 f 0
I 0 0 00000000 0 00000001
W 0 2 00000004 f 0
R 0 2 00000004 0 00000000
I 0 0 00000000 0 00000000
W 4 0 00000052 f 0
W 4 1 00000004 f 0
W 4 2 00000002 f 0
W 0 0 0000000f f 0
S 4 0 00000020 0 0
G 0 0 00000002 0 0
R 0 2 00000800 0 00000000
R 4 3 0000ffff 0 00000000
G 0 0 00000005 0 0
D 4 1 00000004 0 00000002
R 0 2 00000800 0 00000800
R 0 0 ffffffff 0 0000000f

//--- sim/tb_clk_gen.sv
//----------------------------------------------------------------------------
// Testbench clock and reset source, 100 ns clock and 2 cycles of reset
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 50,     // ns
    parameter int RST_CYCLES  = 2
) (
    output logic mclk,
    output logic rst_n
);

    initial begin
        mclk = 1'b0;
        forever #(HALF_PERIOD) mclk = ~mclk;
    end

    // Release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        rst_n = 1'b1;
    end

endmodule

//--- sim/tb_pwm_top.sv
//----------------------------------------------------------------------------
// Testbench for the PWM unit
// Runs the steps of sim/pwm_cases.txt on the register bus, the pads and the
// waveforms, and stops at the first mismatch
//----------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_pwm_top;
    import pwm_pkg::*;

    localparam int NUM_CH       = 6;
    localparam int MAX_CASES    = 128;
    localparam int CYC_PER_CASE = 4000;     // Watchdog budget per step

    logic              mclk;
    logic              rst_n;
    logic              reg_cs;
    logic              reg_wr;
    logic [4:0]        reg_addr;            // Window and offset
    reg_data_t         reg_wdata;
    reg_be_t           reg_be;
    reg_data_t         reg_rdata;
    logic              reg_ack;
    gpio_t             pad_gpio;
    logic [NUM_CH-1:0] pwm_wfm;
    logic              pwm_intr;

    // Parsed steps
    logic [7:0]        c_op   [MAX_CASES];
    logic [2:0]        c_win  [MAX_CASES];
    logic [1:0]        c_ofs  [MAX_CASES];
    logic [31:0]       c_data [MAX_CASES];
    logic [3:0]        c_be   [MAX_CASES];
    logic [31:0]       c_exp  [MAX_CASES];
    int                n_cases;
    logic              loaded;

    tb_clk_gen i_clk (
        .mclk  (mclk),
        .rst_n (rst_n)
    );

    pwm_top #(
        .NUM_CH    (NUM_CH)
    ) i_dut (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .reg_cs    (reg_cs),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_be    (reg_be),
        .reg_rdata (reg_rdata),
        .reg_ack   (reg_ack),
        .pad_gpio  (pad_gpio),
        .pwm_wfm   (pwm_wfm),
        .pwm_intr  (pwm_intr)
    );

    //------------------------------------------------------------------------
    // Error reporting
    //------------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        fail_run($sformatf("Fail at %0d ns: %s expected 0x%08h, got 0x%08h",
                           $time, name, exp, act));
    endtask

    //------------------------------------------------------------------------
    // Step file
    //------------------------------------------------------------------------
    task automatic load_cases();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  op;
        logic [31:0] f_win;
        logic [31:0] f_ofs;
        logic [31:0] f_data;
        logic [31:0] f_be;
        logic [31:0] f_exp;
        n_cases = 0;
        fd = $fopen("sim/pwm_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the step file sim/pwm_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                code = $sscanf(line, "%c %h %h %h %h %h",
                               op, f_win, f_ofs, f_data, f_be, f_exp);
                if (code == 6 && op != "#" && n_cases < MAX_CASES) begin
                    c_op[n_cases]   = op;
                    c_win[n_cases]  = f_win[2:0];
                    c_ofs[n_cases]  = f_ofs[1:0];
                    c_data[n_cases] = f_data;
                    c_be[n_cases]   = f_be[3:0];
                    c_exp[n_cases]  = f_exp;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    //------------------------------------------------------------------------
    // Bus, pad and waveform tasks
    //------------------------------------------------------------------------
    // Master holds the request until it sees the ack
    task automatic bus_access(input logic [2:0] win, input logic [1:0] ofs,
                              input logic wr, input logic [31:0] data,
                              input logic [3:0] be, output logic [31:0] rdata);
        int lat;
        lat = 0;
        @(negedge mclk);
        assert (reg_ack == 1'b0)            // Previous ack lasted one cycle
            else value_error("reg_ack before request", 32'd0, reg_ack);
        reg_cs    = 1'b1;
        reg_wr    = wr;
        reg_addr  = {win, ofs};
        reg_wdata = data;
        reg_be    = be;
        do begin
            @(negedge mclk);
            lat++;
        end while (!reg_ack);
        assert (lat == 1)                   // Ack one cycle after the select
            else value_error("reg_ack latency in cycles", 32'd1, lat);
        rdata  = reg_rdata;
        reg_cs = 1'b0;
        reg_wr = 1'b0;
    endtask

    // From a rising edge, count n cycles spent at lvl
    task automatic count_level(input int ch, input logic lvl, input int n, input int exp);
        logic prev;
        logic cur;
        int   cnt;
        @(negedge mclk);
        prev = pwm_wfm[ch];
        @(negedge mclk);
        cur = pwm_wfm[ch];
        while (!(cur && !prev)) begin       // Watchdog covers a dead output
            prev = cur;
            @(negedge mclk);
            cur = pwm_wfm[ch];
        end
        cnt = (cur == lvl) ? 1 : 0;
        repeat (n - 1) begin
            @(negedge mclk);
            if (pwm_wfm[ch] == lvl) cnt++;
        end
        assert (cnt == exp)
            else value_error($sformatf("pwm_wfm[%0d] level count", ch), exp, cnt);
    endtask

    task automatic check_steady(input int ch, input logic lvl, input int n);
        repeat (n) begin
            @(negedge mclk);
            assert (pwm_wfm[ch] == lvl)
                else value_error($sformatf("pwm_wfm[%0d]", ch), lvl, pwm_wfm[ch]);
        end
    endtask

    task automatic pulse_gpio(input int idx);
        @(negedge mclk);
        pad_gpio[idx] = 1'b1;
        repeat (4) @(negedge mclk);
        pad_gpio[idx] = 1'b0;
    endtask

    // Interrupt follows status one cycle later, allow a few cycles
    task automatic expect_intr(input logic lvl);
        int k;
        k = 0;
        while (pwm_intr !== lvl && k < 8) begin
            @(negedge mclk);
            k++;
        end
        assert (pwm_intr === lvl) else value_error("pwm_intr", lvl, pwm_intr);
    endtask

    //------------------------------------------------------------------------
    // Main sequence and watchdog
    //------------------------------------------------------------------------
    initial begin
        logic [31:0] rdata;
        reg_cs    = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_be    = '0;
        pad_gpio  = '0;
        loaded    = 1'b0;
        load_cases();
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i < n_cases; i++) begin
            case (c_op[i])
                "W": bus_access(c_win[i], c_ofs[i], 1'b1, c_data[i], c_be[i], rdata);
                "R": begin                  // Data column is the compare mask
                    bus_access(c_win[i], c_ofs[i], 1'b0, '0, '0, rdata);
                    assert ((rdata & c_data[i]) == (c_exp[i] & c_data[i]))
                        else value_error($sformatf("reg_rdata win %0d ofs %0d",
                                                   c_win[i], c_ofs[i]),
                                         c_exp[i] & c_data[i], rdata & c_data[i]);
                end
                "D": count_level(int'(c_win[i]) - 1, c_ofs[i][0], c_data[i], c_exp[i]);
                "S": check_steady(int'(c_win[i]) - 1, c_ofs[i][0], c_data[i]);
                "G": pulse_gpio(c_data[i]);
                "I": expect_intr(c_exp[i][0]);
                default: fail_run($sformatf("Unknown step '%c' in the step file", c_op[i]));
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (n_cases * CYC_PER_CASE) @(posedge mclk);
        fail_run($sformatf("Watchdog expired after %0d cycles, a step never finished",
                           n_cases * CYC_PER_CASE));
    end

endmodule
